// File: sim/cpuTestdata.txt
# T name | I instruction word (hex, ROM from 0) | W rd(dec) data(hex), in order
T alu
I 910017E1
I 91000C22
I 8B020023
I CB010064
I CB030025
I 14000000
I 8B1F03FF
W 1 5
W 2 8
W 3 D
W 4 8
W 5 FFFFFFFFFFFFFFF8
T zero
I 910027E1
I 91001C3F
I 8B0103E2
I CB1F0043
I 14000000
I 8B1F03FF
W 1 9
W 2 9
W 3 9
T mem
I 91048FE1
I 910043E2
I 8B1F03FF
I F8008041
I F81F8042
I F8408043
I F84083E4
I 8B1F03FF
I 8B040065
I 14000000
I 8B1F03FF
W 1 123
W 2 10
W 3 123
W 4 10
W 5 133
T branch
I 910007E1
I 14000003
I 91000BE2
I 91000FE3
I 910013E4
I 14000000
I 8B1F03FF
W 1 1
W 2 2
W 4 4
T cbz
I 910003E1
I B4000061
I 91001FE2
I 910027E3
I 910007E4
I B4000064
I 910003E5
I 8B1F03FF
I 8B1F03FF
I B4000065
I 91001BE6
I 91001FE7
I 910023E8
I 14000000
I 8B1F03FF
W 1 0
W 2 7
W 4 1
W 5 0
W 6 6
W 8 8

// File: build.f
source/cpuPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memWbStage.sv
source/cpuCore.sv
sim/cpuCoreTb.sv

// File: run.sh
#!/bin/bash
# Build and run the cpuCore testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary -f build.f --top-module cpuCoreTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" <<< "$out"; then
    exit 0
fi
exit 1

// File: sim/cpuCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCoreTb import cpuPkg::*; ();

    localparam int     ROM_WORDS = 64;
    localparam int     MAX_TESTS = 16;
    localparam int     MAX_ITEMS = 1024;
    localparam instr_t NOP_WORD  = 32'h8B1F03FF;  // ADD XZR,XZR,XZR

    logic      clk;
    logic      rstN;
    instr_t    instr;
    word_t     fetchPc;
    regWrite_t wb;

    // Test table filled from the data file
    string  testName [MAX_TESTS];
    int     romBase [MAX_TESTS];
    int     romLen [MAX_TESTS];
    int     expBase [MAX_TESTS];
    int     expLen [MAX_TESTS];
    instr_t progWords [MAX_ITEMS];
    int     expRd [MAX_ITEMS];
    word_t  expData [MAX_ITEMS];
    instr_t romImg [ROM_WORDS];
    int     numTests;
    int     errors;
    bit     tableReady;

    cpuCore #(
        .DATA_WORDS (64)
    ) cpuCore_inst (
        .clk     (clk),
        .rstN    (rstN),
        .instr   (instr),
        .fetchPc (fetchPc),
        .wb      (wb)
    );

    always #4 clk = ~clk;       // 8 ns period

    // Synchronous ROM, word appears one cycle after its address
    always @(posedge clk) begin
        if ((fetchPc >> 2) < ROM_WORDS) begin
            instr <= romImg[fetchPc >> 2];
        end else begin
            instr <= NOP_WORD;
        end
    end

    // ========================================
    // Checks and data file
    // ========================================
    task automatic checkValue(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic readTable();
        int     fd;
        int     nWords;
        int     nExp;
        int     rd;
        string  line;
        instr_t w;
        word_t  d;
        nWords   = 0;
        nExp     = 0;
        numTests = 0;
        fd = $fopen("sim/cpuTestdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open sim/cpuTestdata.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 2 && line[0] == "T") begin
                    testName[numTests] = line.substr(2, line.len() - 2);
                    romBase[numTests]  = nWords;
                    romLen[numTests]   = 0;
                    expBase[numTests]  = nExp;
                    expLen[numTests]   = 0;
                    numTests++;
                end else if (line.len() > 2 && line[0] == "I") begin
                    void'($sscanf(line, "I %h", w));
                    progWords[nWords] = w;
                    nWords++;
                    romLen[numTests - 1]++;
                end else if (line.len() > 2 && line[0] == "W") begin
                    void'($sscanf(line, "W %d %h", rd, d));
                    expRd[nExp]   = rd;
                    expData[nExp] = d;
                    nExp++;
                    expLen[numTests - 1]++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Idle, reset, load ROM, release, then follow wb for the test's budget
    task automatic runTest(input int t, output bit passed);
        int budget;
        int seen;
        int errsBefore;
        int idle;
        errsBefore = errors;
        budget     = 20 * romLen[t] + 20;
        seen       = 0;
        idle       = $urandom_range(0, 3);
        repeat (idle) @(posedge clk);     // Pipeline spins in the end loop
        @(posedge clk);
        rstN <= 1'b0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            romImg[i] = (i < romLen[t]) ? progWords[romBase[t] + i] : NOP_WORD;
        end
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("fetchPc after reset", fetchPc, 64'd0);
        for (int c = 0; c < budget; c++) begin
            @(negedge clk);
            if (wb.valid) begin
                if (seen < expLen[t]) begin
                    checkValue("wb.rd", word_t'(wb.rd), word_t'(expRd[expBase[t] + seen]));
                    checkValue("wb.data", wb.data, expData[expBase[t] + seen]);
                end
                seen++;
            end
        end
        if (seen != expLen[t]) begin
            errors++;
            $display("test %s saw %0d register writes but expected %0d",
                     testName[t], seen, expLen[t]);
        end
        passed = (errors == errsBefore);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int  nPass;
        bit  ok;
        clk        = 1'b0;
        rstN       = 1'b0;
        instr      = NOP_WORD;
        errors     = 0;
        nPass      = 0;
        tableReady = 1'b0;
        void'($urandom(32'hda3a));  // Seed once for the idle cycles
        readTable();
        tableReady = 1'b1;
        for (int t = 0; t < numTests; t++) begin
            runTest(t, ok);
            if (ok) begin
                nPass++;
            end
            $display("test %s: %s", testName[t], ok ? "pass" : "fail");
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 numTests, nPass, numTests - nPass, errors);
        if (errors == 0 && numTests > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog from the per-test budgets plus reset and idle slack
    initial begin
        longint limit;
        wait (tableReady);
        limit = 0;
        for (int t = 0; t < numTests; t++) begin
            limit += 20 * romLen[t] + 20 + 12;
        end
        #(limit * 8 + 100);
        $display("simulation timed out before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cpuCore.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCore import cpuPkg::*; #(
    parameter int DATA_WORDS = 64
) (
    input  logic      clk,
    input  logic      rstN,
    input  instr_t    instr,          // Synchronous ROM output
    output word_t     fetchPc,
    output regWrite_t wb              // Observed writebacks
);

    // ========================================
    // Inter-stage wires
    // ========================================
    logic      branchTaken;
    word_t     branchTarget;
    word_t     pcId;
    idEx_t     idEx;
    exMem_t    exMem;
    regWrite_t exFwd;

    fetchStage fetchStage_inst (
        .clk          (clk),
        .rstN         (rstN),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .fetchPc      (fetchPc),
        .pcId         (pcId)
    );

    decodeStage decodeStage_inst (
        .clk          (clk),
        .rstN         (rstN),
        .instr        (instr),
        .pcId         (pcId),
        .wb           (wb),
        .exFwd        (exFwd),
        .idEx         (idEx),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    executeStage executeStage_inst (
        .clk   (clk),
        .rstN  (rstN),
        .idEx  (idEx),
        .wb    (wb),
        .exMem (exMem),
        .exFwd (exFwd)
    );

    memWbStage #(
        .DATA_WORDS (DATA_WORDS)
    ) memWbStage_inst (
        .clk   (clk),
        .rstN  (rstN),
        .exMem (exMem),
        .wb    (wb)
    );

endmodule

`default_nettype wire

// File: source/memWbStage.sv
`timescale 1ns/10ps
`default_nettype none

module memWbStage import cpuPkg::*; #(
    parameter int DATA_WORDS = 64         // Depth in 64-bit words
) (
    input  logic      clk,
    input  logic      rstN,
    input  exMem_t    exMem,
    output regWrite_t wb
);

    localparam int ADDR_W = (DATA_WORDS > 1) ? $clog2(DATA_WORDS) : 1;

    word_t             mem [DATA_WORDS];
    word_t             wordIdx;           // Byte address / 8
    logic [ADDR_W-1:0] memIdx;
    word_t             loadData;
    memWb_t            memWb;

    assign wordIdx  = exMem.aluRes >> 3;
    assign memIdx   = wordIdx[ADDR_W-1:0];
    assign loadData = exMem.memRead ? mem[memIdx] : '0;   // Combinational read

    // ========================================
    // Data memory and MEM/WB register
    // ========================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (exMem.memWrite) begin
            mem[memIdx] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memRead;   // Loads write memory data
            memWb.rd       <= exMem.rd;
            memWb.aluRes   <= exMem.aluRes;
            memWb.loadData <= loadData;
        end
    end

    assign wb.valid = memWb.regWrite && memWb.rd != ZERO_REG;
    assign wb.rd    = memWb.rd;
    assign wb.data  = memWb.memToReg ? memWb.loadData : memWb.aluRes;

    // Address comes from execute, offset from the program
    accessInRange: assert property (@(posedge clk) disable iff (!rstN)
        (exMem.memRead || exMem.memWrite) |->
            (exMem.aluRes[2:0] == 3'b000 && wordIdx < DATA_WORDS))
        else $error("bad data address %h", exMem.aluRes);

endmodule

`default_nettype wire

// File: source/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage import cpuPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  idEx_t     idEx,
    input  regWrite_t wb,             // Writeback stage result
    output exMem_t    exMem,
    output regWrite_t exFwd           // To decode CBZ check
);

    word_t  opA, opB, aluB, imm, result;
    exMem_t exMemNext;

    // ========================================
    // Forwarding
    // ========================================
    // Memory stage beats writeback, both beat decode's value
    function automatic word_t forwardOp(
        regAddr_t  src,
        word_t     regVal,
        exMem_t    memStage,
        regWrite_t wbStage
    );
        logic memHit;
        memHit = memStage.regWrite && memStage.rd != ZERO_REG
                 && memStage.rd == src;
        if (memHit) begin
            return memStage.aluRes;
        end else if (wbStage.valid && wbStage.rd == src) begin
            return wbStage.data;
        end
        return regVal;
    endfunction

    assign opA = forwardOp(idEx.rn, idEx.rnVal, exMem, wb);
    assign opB = forwardOp(idEx.rm, idEx.rmVal, exMem, wb);   // Also STUR data

    // ========================================
    // Immediate and ALU
    // ========================================
    assign imm = idEx.zExt ? {52'b0, idEx.imm12}              // ADDI
                           : {{55{idEx.dAddr9[8]}}, idEx.dAddr9};  // Load/store offset
    assign aluB = idEx.aluSrc ? imm : opB;

    always_comb begin
        case (idEx.aluOp)
            ALU_SUB: result = opA - aluB;
            default: result = opA + aluB;
        endcase
    end

    // Result visible to decode in the same cycle
    assign exFwd.valid = idEx.regWrite && idEx.rd != ZERO_REG;
    assign exFwd.rd    = idEx.rd;
    assign exFwd.data  = result;

    always_comb begin
        exMemNext.regWrite  = idEx.regWrite;
        exMemNext.memRead   = idEx.memRead;
        exMemNext.memWrite  = idEx.memWrite;
        exMemNext.rd        = idEx.rd;
        exMemNext.aluRes    = result;
        exMemNext.storeData = opB;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem <= exMemNext;
        end
    end

    // Decode never marks one op as both load and store
    noLoadAndStore: assert property (@(posedge clk) disable iff (!rstN)
        !(idEx.memRead && idEx.memWrite))
        else $error("memRead and memWrite both set");

endmodule

`default_nettype wire

// File: source/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  instr_t    instr,
    input  word_t     pcId,
    input  regWrite_t wb,             // Writeback bus
    input  regWrite_t exFwd,          // Execute result for CBZ
    output idEx_t     idEx,
    output logic      branchTaken,
    output word_t     branchTarget
);

    regAddr_t    rd, rn, rm, reg2;
    opcode_t     opcode;
    logic [25:0] brAddr26;
    logic [18:0] condAddr19;
    logic        instrValid;          // ROM word is stale right after reset
    logic        isB, isCbz, isStur;
    word_t       regs [32];
    word_t       rnVal, reg2Val, cbzVal, brOffset;
    idEx_t       idExNext;

    // ========================================
    // Field extraction
    // ========================================
    assign rd         = instr[RD_LSB +: 5];
    assign rn         = instr[RN_LSB +: 5];
    assign rm         = instr[RM_LSB +: 5];
    assign opcode     = instr[OPCODE_LSB +: 11];
    assign brAddr26   = instr[BR26_LSB +: 26];
    assign condAddr19 = instr[COND19_LSB +: 19];

    assign isB    = instrValid && (opcode[10:5] == OP_B);
    assign isCbz  = instrValid && (opcode[10:3] == OP_CBZ);
    assign isStur = (opcode == OP_STUR);
    assign reg2   = (isCbz || isStur) ? rd : rm;   // Rd is the source here

    // ========================================
    // Register file with write-through
    // ========================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rnVal   = (rn == ZERO_REG) ? '0 :
                     (wb.valid && wb.rd == rn) ? wb.data : regs[rn];
    assign reg2Val = (reg2 == ZERO_REG) ? '0 :
                     (wb.valid && wb.rd == reg2) ? wb.data : regs[reg2];

    // ========================================
    // Branch decision
    // ========================================
    assign cbzVal = (exFwd.valid && exFwd.rd == rd) ? exFwd.data : reg2Val;
    assign branchTaken = isB || (isCbz && cbzVal == '0);
    assign brOffset = isB ? {{38{brAddr26[25]}}, brAddr26}
                          : {{45{condAddr19[18]}}, condAddr19};
    assign branchTarget = pcId + (brOffset << 2);   // Word offset

    // Control decode
    always_comb begin
        idExNext        = '0;         // Unknown opcode leaves strobes low
        idExNext.rn     = rn;
        idExNext.rm     = reg2;
        idExNext.rd     = rd;
        idExNext.rnVal  = rnVal;
        idExNext.rmVal  = reg2Val;
        idExNext.imm12  = instr[IMM12_LSB +: 12];
        idExNext.dAddr9 = instr[DADDR9_LSB +: 9];
        if (instrValid) begin
            if (opcode == OP_ADD || opcode == OP_SUB) begin
                idExNext.regWrite = 1'b1;
                idExNext.aluOp    = (opcode == OP_SUB) ? ALU_SUB : ALU_ADD;
            end else if (opcode[10:1] == OP_ADDI[10:1]) begin
                idExNext.regWrite = 1'b1;
                idExNext.aluSrc   = 1'b1;
                idExNext.zExt     = 1'b1;
            end else if (opcode == OP_LDUR) begin
                idExNext.regWrite = 1'b1;
                idExNext.memRead  = 1'b1;
                idExNext.aluSrc   = 1'b1;
            end else if (isStur) begin
                idExNext.memWrite = 1'b1;
                idExNext.aluSrc   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrValid <= 1'b0;
            idEx       <= '0;
        end else begin
            instrValid <= 1'b1;
            idEx       <= idExNext;
        end
    end

    // Writeback side must drop writes to XZR
    noZeroRegWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(wb.valid && wb.rd == ZERO_REG))
        else $error("write to ZERO_REG on wb");

endmodule

`default_nettype wire

// File: source/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage import cpuPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  branchTaken,     // From decode, same cycle
    input  word_t branchTarget,
    output word_t fetchPc,         // To instruction ROM
    output word_t pcId             // PC of the word now in decode
);

    word_t pc;
    word_t pcNext;

    assign fetchPc = pc;

    // Delay slot already fetched, so the target lands one cycle later
    assign pcNext = branchTaken ? branchTarget : pc + 64'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc   <= '0;           // Restart at address 0
            pcId <= '0;
        end else begin
            pc   <= pcNext;
            pcId <= pc;           // Travels with the ROM output
        end
    end

    // Branch targets from decode keep word alignment
    pcAligned: assert property (@(posedge clk) disable iff (!rstN)
        fetchPc[1:0] == 2'b00)
        else $error("fetchPc misaligned: %h", fetchPc);

endmodule

`default_nettype wire

// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // ========================================
    // Widths with a meaning
    // ========================================
    typedef logic [63:0] word_t;        // Register value, address, PC
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [10:0] opcode_t;
    typedef logic [11:0] imm12_t;       // ADDI immediate
    typedef logic [8:0]  dAddr9_t;      // LDUR/STUR byte offset

    localparam regAddr_t ZERO_REG = 5'd31;  // XZR, reads zero

    // Field positions in the instruction word
    localparam int RD_LSB     = 0;
    localparam int RN_LSB     = 5;
    localparam int RM_LSB     = 16;
    localparam int IMM12_LSB  = 10;
    localparam int DADDR9_LSB = 12;
    localparam int OPCODE_LSB = 21;
    localparam int COND19_LSB = 5;      // CBZ offset
    localparam int BR26_LSB   = 0;      // B offset

    // ========================================
    // Opcodes
    // ========================================
    localparam opcode_t OP_ADD  = 11'b10001011000;
    localparam opcode_t OP_SUB  = 11'b11001011000;
    localparam opcode_t OP_ADDI = 11'b10010001000;  // Bit 0 belongs to imm12
    localparam opcode_t OP_LDUR = 11'b11111000010;
    localparam opcode_t OP_STUR = 11'b11111000000;

    localparam logic [5:0] OP_B   = 6'b000101;      // opcode[10:5]
    localparam logic [7:0] OP_CBZ = 8'b10110100;    // opcode[10:3]

    typedef enum logic {
        ALU_ADD,
        ALU_SUB
    } aluOp_t;

    // ========================================
    // Stage buses
    // ========================================
    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     aluSrc;       // Immediate as operand B
        logic     zExt;         // Zero-extend imm12 instead of dAddr9
        aluOp_t   aluOp;
        regAddr_t rn;
        regAddr_t rm;           // Rm, or Rd for STUR
        regAddr_t rd;
        word_t    rnVal;
        word_t    rmVal;
        imm12_t   imm12;
        dAddr9_t  dAddr9;
    } idEx_t;

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        regAddr_t rd;
        word_t    aluRes;       // Also the memory address
        word_t    storeData;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        regAddr_t rd;
        word_t    aluRes;
        word_t    loadData;
    } memWb_t;

    typedef struct packed {
        logic     valid;        // Never set for ZERO_REG
        regAddr_t rd;
        word_t    data;
    } regWrite_t;

endpackage

`default_nettype wire
